/* flow_arb_defines.svh */
// Requester count must be at least 2 and the data width at least 1; edit the values here only
`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

// ------------------------------------------------------------
// Arbiter sizing
// ------------------------------------------------------------

// Number of requesters feeding the arbiter
// Lower index starts with the higher priority after reset
`define ARB_NUM_REQ 4

// Width of the payload word carried by each requester
`define ARB_DATA_W 16

// ------------------------------------------------------------
// Notes
// ------------------------------------------------------------

// The package derives every shared type from these two values
// Module parameters default to them, so change them here only

`endif

/* flow_arb_pkg.sv */
// Types follow the macros in flow_arb_defines.svh; the index type needs ARB_NUM_REQ >= 2
`include "flow_arb_defines.svh"

package flow_arb_pkg;

  // ------------------------------------------------------------
  // Requester side
  // ------------------------------------------------------------

  // Binary index of one requester
  typedef logic [$clog2(`ARB_NUM_REQ)-1:0] req_idx_t;

  // One bit per requester, used for valids, readies and grants
  typedef logic [`ARB_NUM_REQ-1:0] req_vec_t;

  // Payload word offered by each requester
  typedef logic [`ARB_DATA_W-1:0] data_t;

  // ------------------------------------------------------------
  // Output side
  // ------------------------------------------------------------

  // Winning word tagged with the index it came from
  // src sits in the low bits of the packed struct
  typedef struct packed {
    data_t    data;
    req_idx_t src;
  } item_t;

endpackage : flow_arb_pkg

/* arb_lru.sv */
// Purely combinational grant with LRU state; NUM_REQ must equal ARB_NUM_REQ since ports use req_vec_t
`timescale 1ns/1ps
`include "flow_arb_defines.svh"

module arb_lru
  import flow_arb_pkg::*;
#(
  // At least 2
  parameter int NUM_REQ = `ARB_NUM_REQ
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     enable,
  input  req_vec_t request,
  output req_vec_t grant
);

  // ------------------------------------------------------------
  // Priority matrix
  // ------------------------------------------------------------

  // beats_q[i][j] set means requester i wins over requester j
  // Off-diagonal pairs always hold opposite values
  // Diagonal bits stay zero and are never read
  logic [NUM_REQ-1:0][NUM_REQ-1:0] beats_q;
  logic [NUM_REQ-1:0][NUM_REQ-1:0] beats_d;

  // Reset order with index 0 highest and NUM_REQ-1 lowest
  function automatic logic [NUM_REQ-1:0][NUM_REQ-1:0] init_order();
    logic [NUM_REQ-1:0][NUM_REQ-1:0] m;
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = 0; j < NUM_REQ; j++) begin
        m[i][j] = (i < j);
      end
    end
    return m;
  endfunction

  // ------------------------------------------------------------
  // Grant
  // ------------------------------------------------------------

  // A requester wins when it beats every other active requester
  // The matrix is a total order, so at most one bit survives
  // Enable low forces the grant to zero
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      grant[i] = enable & request[i];
      for (int j = 0; j < NUM_REQ; j++) begin
        if (j != i) begin
          // Inactive rivals never block
          grant[i] &= ~request[j] | beats_q[i][j];
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Priority update
  // ------------------------------------------------------------

  // Winner row clears and winner column sets
  // Winner drops to the bottom, the rest keep their relative order
  always_comb begin
    beats_d = beats_q;
    for (int i = 0; i < NUM_REQ; i++) begin
      for (int j = 0; j < NUM_REQ; j++) begin
        if (i != j) begin
          if (grant[i]) begin
            beats_d[i][j] = 1'b0;
          end else if (grant[j]) begin
            beats_d[i][j] = 1'b1;
          end
        end
      end
    end
  end

  // State only moves on an enabled grant
  // Without a grant beats_d equals beats_q
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      beats_q <= init_order();
    end else begin
      beats_q <= beats_d;
    end
  end

endmodule : arb_lru

/* flow_arb_lru.sv */
// Zero-cycle valid/ready arbiter; pop_valid ignores pop_ready and NUM_REQ must equal ARB_NUM_REQ
`timescale 1ns/1ps
`include "flow_arb_defines.svh"

module flow_arb_lru
  import flow_arb_pkg::*;
#(
  // At least 2
  parameter int NUM_REQ = `ARB_NUM_REQ
) (
  input  logic     clk,
  input  logic     arst_n,
  input  req_vec_t push_valid,
  output req_vec_t push_ready,
  input  logic     pop_ready,
  output logic     pop_valid,
  output req_vec_t grant
);

  // ------------------------------------------------------------
  // Arbiter core
  // ------------------------------------------------------------

  // Pop ready enables the core so priority only moves on a transfer
  arb_lru #(
    .NUM_REQ(NUM_REQ)
  ) u_core (
    .clk    (clk),
    .arst_n (arst_n),
    .enable (pop_ready),
    .request(push_valid),
    .grant  (grant)
  );

  // ------------------------------------------------------------
  // Handshake outputs
  // ------------------------------------------------------------

  // Requester i is ready when the output accepts and nobody else holds the grant
  // Own valid never enters its own ready
  // Ready AND valid then equals the grant
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      push_ready[i] = pop_ready;
      for (int j = 0; j < NUM_REQ; j++) begin
        if (j != i) begin
          push_ready[i] &= ~grant[j];
        end
      end
    end
  end

  // Some requester is always offered when any valid is up
  assign pop_valid = |push_valid;

endmodule : flow_arb_lru

/* flow_mux_lru.sv */
// Zero-cycle path from push to pop; the item is all zeros when nothing is granted
`timescale 1ns/1ps
`include "flow_arb_defines.svh"

module flow_mux_lru
  import flow_arb_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  req_vec_t push_valid,
  output req_vec_t push_ready,
  input  data_t    push_data [`ARB_NUM_REQ],
  input  logic     pop_ready,
  output logic     pop_valid,
  output item_t    pop_item
);

  // ------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------

  // One-hot grant from the LRU arbiter
  req_vec_t grant;

  // Selected word and its source index
  data_t    sel_data;
  req_idx_t sel_src;

  flow_arb_lru #(
    .NUM_REQ(`ARB_NUM_REQ)
  ) u_arb (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .grant     (grant)
  );

  // ------------------------------------------------------------
  // Data steering
  // ------------------------------------------------------------

  // AND-OR mux on the one-hot grant
  // Only the granted word survives the masking
  always_comb begin
    sel_data = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      sel_data |= push_data[i] & {`ARB_DATA_W{grant[i]}};
    end
  end

  // One-hot to binary encoder for the tag
  // ORing the indices is exact because at most one grant bit is set
  always_comb begin
    sel_src = '0;
    for (int i = 0; i < `ARB_NUM_REQ; i++) begin
      if (grant[i]) begin
        sel_src |= req_idx_t'(i);
      end
    end
  end

  // Tagged item toward the output stage
  always_comb begin
    pop_item.data = sel_data;
    pop_item.src  = sel_src;
  end

endmodule : flow_mux_lru

/* flow_reg_slice.sv */
// Two-entry skid buffer; one cycle of latency and push_ready comes from a flop only
`timescale 1ns/1ps

module flow_reg_slice
  import flow_arb_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  logic  push_valid,
  output logic  push_ready,
  input  item_t push_item,
  input  logic  pop_ready,
  output logic  pop_valid,
  output item_t pop_item
);

  // ------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------

  // Main entry drives the output
  logic  main_valid_q;
  item_t main_q;

  // Skid entry catches one item while the output stalls
  logic  skid_valid_q;
  item_t skid_q;

  // Transfer and load strobes
  logic push_xfer;
  logic pop_xfer;
  logic main_load_push;
  logic main_load_skid;
  logic skid_load;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------

  // Ready only while the skid entry is free
  assign push_ready = ~skid_valid_q;
  assign push_xfer  = push_valid & push_ready;
  assign pop_xfer   = main_valid_q & pop_ready;

  // A full skid implies a full main, so it refills main on a pop
  assign main_load_skid = skid_valid_q & pop_ready;
  // New item goes straight to main when main is free or draining
  assign main_load_push = push_xfer & (~main_valid_q | pop_ready);
  // Otherwise it parks in the skid entry
  assign skid_load      = push_xfer & main_valid_q & ~pop_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else begin
      if (main_load_push || main_load_skid) begin
        main_valid_q <= 1'b1;
      end else if (pop_xfer) begin
        main_valid_q <= 1'b0;
      end
      if (skid_load) begin
        skid_valid_q <= 1'b1;
      end else if (main_load_skid) begin
        skid_valid_q <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // Payload
  // ------------------------------------------------------------

  // Skid content has priority since it is older
  always_ff @(posedge clk) begin
    if (main_load_skid) begin
      main_q <= skid_q;
    end else if (main_load_push) begin
      main_q <= push_item;
    end
    if (skid_load) begin
      skid_q <= push_item;
    end
  end

  assign pop_valid = main_valid_q;
  assign pop_item  = main_q;

endmodule : flow_reg_slice

/* arb_top.sv */
// Arbitrated output arrives one cycle after the push transfer; push_ready drops while the slice is full
`timescale 1ns/1ps
`include "flow_arb_defines.svh"

module arb_top
  import flow_arb_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  req_vec_t push_valid,
  output req_vec_t push_ready,
  input  data_t    push_data [`ARB_NUM_REQ],
  input  logic     pop_ready,
  output logic     pop_valid,
  output item_t    pop_item
);

  // ------------------------------------------------------------
  // Mux to slice link
  // ------------------------------------------------------------

  logic  mux_valid;
  logic  mux_ready;
  item_t mux_item;

  // Arbitration and data select, zero cycles
  flow_mux_lru u_mux (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .pop_ready (mux_ready),
    .pop_valid (mux_valid),
    .pop_item  (mux_item)
  );

  // Output register, cuts ready and valid timing paths
  flow_reg_slice u_slice (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(mux_valid),
    .push_ready(mux_ready),
    .push_item (mux_item),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_item  (pop_item)
  );

endmodule : arb_top

/* tb_arb_top.sv */
// Testbench for arb_top; LFSR stimulus with seed 12, stops at the first mismatch, needs ARB_NUM_REQ >= 3
`timescale 1ns/1ps
`include "flow_arb_defines.svh"

module tb_arb_top
  import flow_arb_pkg::*;
();

  // ------------------------------------------------------------
  // Run length
  // ------------------------------------------------------------

  localparam int NUM_REQ      = `ARB_NUM_REQ;
  localparam int ROT_ITEMS    = 40;
  localparam int DATA_ITEMS   = 200;
  localparam int BP_ITEMS     = 120;
  localparam int SINGLE_ITEMS = 40;
  localparam int TOTAL_ITEMS  = ROT_ITEMS + DATA_ITEMS + BP_ITEMS + SINGLE_ITEMS;
  // Worst case cycles per item with the output stalled
  localparam int STALL_MARGIN = 10;
  localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * STALL_MARGIN;

  // Priority order, entry 0 is the highest
  typedef req_idx_t [NUM_REQ-1:0] order_t;

  // DUT ports
  logic     clk;
  logic     arst_n;
  req_vec_t push_valid;
  req_vec_t push_ready;
  data_t    push_data [NUM_REQ];
  logic     pop_ready;
  logic     pop_valid;
  item_t    pop_item;

  // Stimulus controls
  logic        drive_en;
  int          phase;
  req_vec_t    src_en;
  logic        always_valid;
  int          pop_mode;
  int          stall_left;
  int          seq [NUM_REQ];
  logic [15:0] lfsr_state;

  // Model state
  order_t   prio_order;
  item_t    slice_q [$];
  int       slice_count;
  int       push_count;
  int       pop_count;
  int       rot_idx;
  req_vec_t taken;
  int       win;
  req_vec_t exp_ready;
  req_vec_t xfers;
  item_t    exp_item;

  arb_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_item  (pop_item)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------

  task automatic stop_failed();
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    stop_failed();
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
      stop_failed();
    end
  endtask

  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  // Source index in the top nibble, running count below
  function automatic data_t next_word(input int src, input int n);
    return data_t'(src * 4096 + n % 4096);
  endfunction

  // Highest ranked valid requester, -1 when none or when the output is blocked
  function automatic int lru_winner(input order_t ord, input req_vec_t valid,
                                    input logic enable);
    int w;
    w = -1;
    if (enable) begin
      for (int k = NUM_REQ - 1; k >= 0; k--) begin
        if (valid[ord[k]]) begin
          w = ord[k];
        end
      end
    end
    return w;
  endfunction

  // Winner drops to the end, the others close the gap in order
  function automatic order_t move_last(input order_t ord, input int idx);
    order_t res;
    int     n;
    n = 0;
    for (int k = 0; k < NUM_REQ; k++) begin
      if (ord[k] != req_idx_t'(idx)) begin
        res[n] = ord[k];
        n++;
      end
    end
    res[NUM_REQ-1] = req_idx_t'(idx);
    return res;
  endfunction

  // Moves just past a rising edge so control changes never race the edge
  task automatic step_past_edge();
    @(posedge clk);
    #1;
  endtask

  // Stop all sources and wait until every item is out
  task automatic drain();
    phase    = 0;
    src_en   = '0;
    pop_mode = 0;
    wait (push_valid == '0 && !pop_valid);
    // DUT is idle, so the model must hold nothing either
    check("queue_empty", 0, slice_q.size());
    step_past_edge();
  endtask

  // ------------------------------------------------------------
  // Stimulus, falling edge
  // ------------------------------------------------------------

  always @(negedge clk) begin
    if (drive_en) begin
      // Mode 0 always ready, 1 ready three times in four, 2 stalls in bursts
      case (pop_mode)
        0: pop_ready = 1'b1;
        1: pop_ready = (rand_bits(2) != 0);
        default: begin
          if (stall_left > 0) begin
            pop_ready = 1'b0;
            stall_left--;
          end else if (rand_bits(4) == 0) begin
            pop_ready  = 1'b0;
            stall_left = 4 + rand_bits(3);
          end else begin
            pop_ready = (rand_bits(1) != 0);
          end
        end
      endcase
      for (int i = 0; i < NUM_REQ; i++) begin
        // Next word only after the current one went through
        if (push_valid[i] && taken[i]) begin
          seq[i]++;
          push_data[i]  = next_word(i, seq[i]);
          push_valid[i] = 1'b0;
        end
        if (!push_valid[i] && src_en[i]) begin
          push_valid[i] = always_valid ? 1'b1 : (rand_bits(1) != 0);
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Model and compare, rising edge
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (arst_n) begin
      // Slice accepts while its skid entry is free
      win = lru_winner(prio_order, push_valid, slice_count < 2);
      // Ready needs room in the slice and no grant held by another requester
      for (int i = 0; i < NUM_REQ; i++) begin
        exp_ready[i] = (slice_count < 2) && ((win < 0) || (win == i));
      end
      xfers = push_valid & push_ready;
      if (slice_count == 2) begin
        check("no_push_when_full", 0, xfers);
      end
      check("one_push_per_cycle", 1, $countones(xfers) <= 1);
      // Full load walks the indices in order
      if (phase == 2) begin
        check("lru_rotation", req_vec_t'(1) << (rot_idx % NUM_REQ), xfers);
        rot_idx++;
      end
      // Lone requester never waits
      if (phase == 6 && push_valid[2]) begin
        check("single_req_throughput", 1, xfers[2]);
      end
      if (win >= 0) begin
        check("grant_winner", req_vec_t'(1) << win, xfers);
      end
      check("push_ready", exp_ready, push_ready);
      // Output side sees the slice contents one cycle after the push
      check("pop_valid", slice_count != 0, pop_valid);
      if (pop_valid && pop_ready) begin
        check("pop_item", slice_q[0], pop_item);
        void'(slice_q.pop_front());
        pop_count++;
      end
      if (win >= 0) begin
        exp_item.data = push_data[win];
        exp_item.src  = req_idx_t'(win);
        slice_q.push_back(exp_item);
        prio_order = move_last(prio_order, win);
        push_count++;
      end
      slice_count = slice_q.size();
      taken       = xfers;
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    int target;
    arst_n       = 1'b0;
    drive_en     = 1'b0;
    phase        = 0;
    src_en       = '0;
    always_valid = 1'b0;
    pop_mode     = 0;
    stall_left   = 0;
    push_valid   = '0;
    pop_ready    = 1'b0;
    lfsr_state   = 16'd12;
    slice_count  = 0;
    push_count   = 0;
    pop_count    = 0;
    rot_idx      = 0;
    taken        = '0;
    for (int i = 0; i < NUM_REQ; i++) begin
      seq[i]        = 0;
      push_data[i]  = next_word(i, 0);
      prio_order[i] = req_idx_t'(i);
    end
    // Reset held for 8 cycles, no valids driven
    repeat (8) begin
      @(posedge clk);
      @(negedge clk);
      check("reset_pop_valid", 0, pop_valid);
      check("reset_push_ready", {NUM_REQ{1'b1}}, push_ready);
    end
    arst_n = 1'b1;
    @(negedge clk);
    check("post_reset_pop_valid", 0, pop_valid);
    check("post_reset_push_ready", {NUM_REQ{1'b1}}, push_ready);
    step_past_edge();

    // Full load, indices must rotate
    phase        = 2;
    src_en       = '1;
    always_valid = 1'b1;
    drive_en     = 1'b1;
    wait (push_count >= ROT_ITEMS);
    #1;

    // Random valids, output mostly ready
    phase        = 3;
    always_valid = 1'b0;
    pop_mode     = 1;
    target       = push_count + DATA_ITEMS;
    wait (push_count >= target);
    #1;

    // Output stalled in bursts
    phase    = 5;
    pop_mode = 2;
    target   = push_count + BP_ITEMS;
    wait (push_count >= target);
    #1;
    drain();

    // Requester 2 alone at full rate
    phase        = 6;
    src_en       = req_vec_t'(1) << 2;
    always_valid = 1'b1;
    target       = push_count + SINGLE_ITEMS;
    wait (push_count >= target);
    #1;
    drain();

    $display("Test OK");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("Watchdog expired after %0d cycles with %0d of %0d items delivered",
                        WATCHDOG_CYCLES, pop_count, TOTAL_ITEMS));
  end

endmodule : tb_arb_top

/* sim.f */
+incdir+.
flow_arb_pkg.sv
arb_lru.sv
flow_arb_lru.sv
flow_mux_lru.sv
flow_reg_slice.sv
arb_top.sv
tb_arb_top.sv

/* Bender.yml */
package:
  name: flow_arb_lru

export_include_dirs:
  - .

sources:
  - flow_arb_pkg.sv
  - arb_lru.sv
  - flow_arb_lru.sv
  - flow_mux_lru.sv
  - flow_reg_slice.sv
  - arb_top.sv
  - target: simulation
    files:
      - tb_arb_top.sv
